// ==== design/forthDebug_config.svh ====
`ifndef FORTH_DEBUG_CONFIG_SVH
`define FORTH_DEBUG_CONFIG_SVH

// ***********************************************************
// debug port sizing.
// ***********************************************************

// width of a data word.
`define DATA_WIDTH 16

// width of the debug address register.
`define ADDR_WIDTH 16

// low address bits that index the debug memory, 256 words.
`define MEM_ADDR_BITS 8

// cpu register count, indexed by the low debug address bits.
`define REG_COUNT 8

`endif

// ==== design/debugPkg.sv ====
`default_nettype none

package debugPkg;

	// ***********************************************************
	// debug instruction opcode, bits 3:1 of the instruction.
	// ***********************************************************
	typedef enum logic [2:0] {
		OPX_NONE   = 3'd0,
		OPX_RD_REG = 3'd1,
		OPX_RD_CC  = 3'd2,
		OPX_RD_PC  = 3'd3,
		OPX_RD_MEM = 3'd4,
		OPX_WR_MEM = 3'd5
	} debugOpxT;

	// memory action for the second phase.
	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_READ  = 2'd1,
		BUS_WRITE = 2'd2
	} busSeqT;

	// register file port b read request.
	typedef enum logic {
		REG_NONE = 1'b0,
		REG_RDB  = 1'b1
	} regSeqT;

	// read-back source.
	typedef enum logic [1:0] {
		SEL_DIN       = 2'd0,
		SEL_REGB_DATA = 2'd1,
		SEL_CC_DATA   = 2'd2,
		SEL_PC_A_NEXT = 2'd3
	} debugDataSelT;

	// condition-code group number.
	typedef logic [1:0] ccRegSelT;

	// next-pc rule, codes 4 to 7 act as PC_NEXT.
	typedef enum logic [2:0] {
		PC_NEXT = 3'd0,
		PC_SAME = 3'd1,
		PC_REL  = 3'd2,
		PC_ABS  = 3'd3
	} pcNextSelT;

endpackage

`default_nettype wire

// ==== design/debugDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module debugDecoder import debugPkg::*; (
	input  logic [6:0]   instruction,
	output busSeqT       busSeq,
	output regSeqT       regSeq,
	output debugDataSelT debugDataSel,
	output ccRegSelT     ccRegSel,
	output pcNextSelT    pcNextSel,
	output logic         ldData,
	output logic         addrInc
);

	logic [3:0] op;
	logic [2:0] arg;
	logic       incBit;
	debugOpxT   opx;

	// instruction fields.
	assign op     = instruction[3:0];
	assign arg    = instruction[6:4];
	assign incBit = op[0];
	assign opx    = debugOpxT'(op[3:1]);

	// ***********************************************************
	// opcode to control field map.
	// ***********************************************************
	always_comb begin
		busSeq       = BUS_NONE;
		regSeq       = REG_NONE;
		debugDataSel = SEL_DIN;
		ccRegSel     = '0;
		pcNextSel    = PC_NEXT;
		ldData       = 1'b0;
		addrInc      = 1'b0;

		case (opx)
			OPX_RD_REG: begin
				regSeq       = REG_RDB;
				debugDataSel = SEL_REGB_DATA;
				ldData       = 1'b1;
				addrInc      = incBit;
			end

			OPX_RD_CC: begin
				debugDataSel = SEL_CC_DATA;
				ccRegSel     = arg[1:0];
				ldData       = 1'b1;
			end

			OPX_RD_PC: begin
				debugDataSel = SEL_PC_A_NEXT;
				pcNextSel    = pcNextSelT'(arg);
				ldData       = 1'b1;
			end

			OPX_RD_MEM: begin
				busSeq       = BUS_READ;
				debugDataSel = SEL_DIN;
				ldData       = 1'b1;
				addrInc      = incBit;
			end

			OPX_WR_MEM: begin
				busSeq  = BUS_WRITE;
				addrInc = incBit;
			end

			// none and the undefined codes keep the defaults.
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/debugSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module debugSequencer import debugPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       debugStrobe,
	input  logic [6:0] debugInstruction,
	output logic [6:0] instruction,
	input  busSeqT     busSeq,
	output logic       memWe,
	output logic       debugBusy,
	output logic       debugDone,
	output logic       finish
);

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		PHASE1 = 2'd1,
		PHASE2 = 2'd2
	} seqStateT;

	seqStateT state;

	// ***********************************************************
	// two-phase sequence, strobes while busy are dropped.
	// ***********************************************************
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state       <= IDLE;
			instruction <= '0;
			memWe       <= 1'b0;
			debugDone   <= 1'b0;
		end else begin
			debugDone <= 1'b0;
			case (state)
				IDLE: begin
					if (debugStrobe) begin
						instruction <= debugInstruction;
						state       <= PHASE1;
					end
				end
				PHASE1: begin
					memWe <= (busSeq == BUS_WRITE);
					state <= PHASE2;
				end
				default: begin
					memWe     <= 1'b0;
					debugDone <= 1'b1;
					state     <= IDLE;
				end
			endcase
		end
	end

	assign debugBusy = (state != IDLE);

	// ends the second phase, results land on the next edge.
	assign finish = (state == PHASE2);

endmodule

`default_nettype wire

// ==== design/debugAddrReg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugAddrReg (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   debugAddrLd,
	input  logic [`ADDR_WIDTH-1:0] debugAddrIn,
	input  logic                   addrInc,
	input  logic                   finish,
	output logic [`ADDR_WIDTH-1:0] debugAddr
);

	// host load wins, the port is idle when it comes.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			debugAddr <= '0;
		end else if (debugAddrLd) begin
			debugAddr <= debugAddrIn;
		end else if (finish && addrInc) begin
			// wraps at the full address width.
			debugAddr <= debugAddr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/debugDataPath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugDataPath import debugPkg::*; (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   finish,
	input  logic                   ldData,
	input  debugDataSelT           debugDataSel,
	input  ccRegSelT               ccRegSel,
	input  pcNextSelT              pcNextSel,
	input  logic [`DATA_WIDTH-1:0] debugDin,
	input  logic [`DATA_WIDTH-1:0] memRdata,
	input  logic [`DATA_WIDTH-1:0] regBData,
	input  logic [`DATA_WIDTH-1:0] ccState,
	input  logic [`DATA_WIDTH-1:0] pc,
	output logic [`DATA_WIDTH-1:0] debugDout
);

	logic [`DATA_WIDTH-1:0] pcANext;
	logic [`DATA_WIDTH-1:0] ccData;
	logic [`DATA_WIDTH-1:0] readData;

	// next pc as the cpu would compute it.
	always_comb begin
		case (pcNextSel)
			PC_SAME: pcANext = pc;
			PC_REL:  pcANext = pc + debugDin;
			PC_ABS:  pcANext = debugDin;
			default: pcANext = pc + 1'b1;
		endcase
	end

	// one nibble per condition-code group.
	assign ccData = {{(`DATA_WIDTH-4){1'b0}}, ccState[{ccRegSel, 2'b00} +: 4]};

	always_comb begin
		case (debugDataSel)
			SEL_REGB_DATA: readData = regBData;
			SEL_CC_DATA:   readData = ccData;
			SEL_PC_A_NEXT: readData = pcANext;
			default:       readData = memRdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			debugDout <= '0;
		end else if (finish && ldData) begin
			debugDout <= readData;
		end
	end

endmodule

`default_nettype wire

// ==== design/debugMemory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugMemory (
	input  logic                     clk,
	input  logic                     memWe,
	input  logic [`MEM_ADDR_BITS-1:0] addr,
	input  logic [`DATA_WIDTH-1:0]    wdata,
	output logic [`DATA_WIDTH-1:0]    rdata
);

	localparam int DEPTH = 1 << `MEM_ADDR_BITS;

	logic [`DATA_WIDTH-1:0] mem [DEPTH];

	// ***********************************************************
	// single port, read data registered every cycle.
	// ***********************************************************
	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== design/debugRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugRegFile import debugPkg::*; (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          regWe,
	input  logic [$clog2(`REG_COUNT)-1:0] regWaddr,
	input  logic [`DATA_WIDTH-1:0]        regWdata,
	input  regSeqT                        regSeq,
	input  logic [$clog2(`REG_COUNT)-1:0] rbIndex,
	output logic [`DATA_WIDTH-1:0]        regBData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// cpu write port.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWe) begin
			regs[regWaddr] <= regWdata;
		end
	end

	// debug read port b, holds its value between reads.
	always_ff @(posedge clk) begin
		if (regSeq == REG_RDB) begin
			regBData <= regs[rbIndex];
		end
	end

endmodule

`default_nettype wire

// ==== design/debugTop.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugTop import debugPkg::*; (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          debugStrobe,
	input  logic [6:0]                    debugInstruction,
	input  logic [`DATA_WIDTH-1:0]        debugDin,
	input  logic                          debugAddrLd,
	input  logic [`ADDR_WIDTH-1:0]        debugAddrIn,
	input  logic                          regWe,
	input  logic [$clog2(`REG_COUNT)-1:0] regWaddr,
	input  logic [`DATA_WIDTH-1:0]        regWdata,
	input  logic [`DATA_WIDTH-1:0]        pc,
	input  logic [`DATA_WIDTH-1:0]        ccState,
	output logic [`DATA_WIDTH-1:0]        debugDout,
	output logic                          debugBusy,
	output logic                          debugDone,
	output logic [`ADDR_WIDTH-1:0]        debugAddr
);

	logic [6:0]             instruction;
	busSeqT                 busSeq;
	regSeqT                 regSeq;
	debugDataSelT           debugDataSel;
	ccRegSelT               ccRegSel;
	pcNextSelT              pcNextSel;
	logic                   ldData;
	logic                   addrInc;
	logic                   memWe;
	logic                   finish;
	logic [`DATA_WIDTH-1:0] memRdata;
	logic [`DATA_WIDTH-1:0] regBData;

	// ***********************************************************
	// control.
	// ***********************************************************
	debugSequencer debugSequencer_inst (
		.clk              (clk),
		.rstN             (rstN),
		.debugStrobe      (debugStrobe),
		.debugInstruction (debugInstruction),
		.instruction      (instruction),
		.busSeq           (busSeq),
		.memWe            (memWe),
		.debugBusy        (debugBusy),
		.debugDone        (debugDone),
		.finish           (finish)
	);

	debugDecoder debugDecoder_inst (
		.instruction  (instruction),
		.busSeq       (busSeq),
		.regSeq       (regSeq),
		.debugDataSel (debugDataSel),
		.ccRegSel     (ccRegSel),
		.pcNextSel    (pcNextSel),
		.ldData       (ldData),
		.addrInc      (addrInc)
	);

	debugAddrReg debugAddrReg_inst (
		.clk         (clk),
		.rstN        (rstN),
		.debugAddrLd (debugAddrLd),
		.debugAddrIn (debugAddrIn),
		.addrInc     (addrInc),
		.finish      (finish),
		.debugAddr   (debugAddr)
	);

	// ***********************************************************
	// storage and read-back.
	// ***********************************************************
	debugMemory debugMemory_inst (
		.clk   (clk),
		.memWe (memWe),
		.addr  (debugAddr[`MEM_ADDR_BITS-1:0]),
		.wdata (debugDin),
		.rdata (memRdata)
	);

	// register index comes from the low debug address bits.
	debugRegFile debugRegFile_inst (
		.clk      (clk),
		.rstN     (rstN),
		.regWe    (regWe),
		.regWaddr (regWaddr),
		.regWdata (regWdata),
		.regSeq   (regSeq),
		.rbIndex  (debugAddr[$clog2(`REG_COUNT)-1:0]),
		.regBData (regBData)
	);

	debugDataPath debugDataPath_inst (
		.clk          (clk),
		.rstN         (rstN),
		.finish       (finish),
		.ldData       (ldData),
		.debugDataSel (debugDataSel),
		.ccRegSel     (ccRegSel),
		.pcNextSel    (pcNextSel),
		.debugDin     (debugDin),
		.memRdata     (memRdata),
		.regBData     (regBData),
		.ccState      (ccState),
		.pc           (pc),
		.debugDout    (debugDout)
	);

endmodule

`default_nettype wire

// ==== verif/debugTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "forthDebug_config.svh"

module debugTb;

	localparam int NUM_WORDS     = 16;
	localparam int NUM_REG_READS = 24;
	localparam int NUM_CCPC      = 32;
	localparam int NUM_QUIET     = 16;
	localparam int MAX_WAIT      = 8;
	localparam int MEM_DEPTH     = 1 << `MEM_ADDR_BITS;
	localparam int REG_BITS      = $clog2(`REG_COUNT);

	// three ops per memory word and an address load per register read.
	localparam int TOTAL_OPS   = 3 * NUM_WORDS + 2 * NUM_REG_READS + `REG_COUNT +
		NUM_CCPC + NUM_QUIET;
	localparam int WATCHDOG_NS = TOTAL_OPS * 4 * 4 + 400;

	localparam logic [2:0] OP_NONE   = 3'd0;
	localparam logic [2:0] OP_RD_REG = 3'd1;
	localparam logic [2:0] OP_RD_CC  = 3'd2;
	localparam logic [2:0] OP_RD_PC  = 3'd3;
	localparam logic [2:0] OP_RD_MEM = 3'd4;
	localparam logic [2:0] OP_WR_MEM = 3'd5;

	localparam logic [2:0] QUIET_OPS [4] = '{OP_NONE, 3'd6, 3'd7, OP_WR_MEM};
	localparam logic [2:0] BUSY_OPS [4]  = '{OP_RD_REG, OP_RD_CC, OP_RD_PC, OP_WR_MEM};

	logic                   clk;
	logic                   rstN;
	logic                   debugStrobe;
	logic [6:0]             debugInstruction;
	logic [`DATA_WIDTH-1:0] debugDin;
	logic                   debugAddrLd;
	logic [`ADDR_WIDTH-1:0] debugAddrIn;
	logic                   regWe;
	logic [REG_BITS-1:0]    regWaddr;
	logic [`DATA_WIDTH-1:0] regWdata;
	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] ccState;
	logic [`DATA_WIDTH-1:0] debugDout;
	logic                   debugBusy;
	logic                   debugDone;
	logic [`ADDR_WIDTH-1:0] debugAddr;

	// reference model state.
	logic [31:0]            rngState;
	logic [`DATA_WIDTH-1:0] memModel [MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] regModel [`REG_COUNT];
	logic [`ADDR_WIDTH-1:0] expAddr;
	logic [`DATA_WIDTH-1:0] expDout;

	debugTop debugTop_inst (
		.clk              (clk),
		.rstN             (rstN),
		.debugStrobe      (debugStrobe),
		.debugInstruction (debugInstruction),
		.debugDin         (debugDin),
		.debugAddrLd      (debugAddrLd),
		.debugAddrIn      (debugAddrIn),
		.regWe            (regWe),
		.regWaddr         (regWaddr),
		.regWdata         (regWdata),
		.pc               (pc),
		.ccState          (ccState),
		.debugDout        (debugDout),
		.debugBusy        (debugBusy),
		.debugDone        (debugDone),
		.debugAddr        (debugAddr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	// ***********************************************************
	// helpers.
	// ***********************************************************
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// argument in 6:4, opcode in 3:1, increment flag in bit 0.
	function automatic logic [6:0] makeInstr(input logic [2:0] opx, input logic [2:0] arg,
		input logic inc);
		return {arg, opx, inc};
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] pcRule(input logic [2:0] sel,
		input logic [`DATA_WIDTH-1:0] pcVal, input logic [`DATA_WIDTH-1:0] din);
		case (sel)
			3'd1: return pcVal;
			3'd2: return pcVal + din;
			3'd3: return din;
			default: return pcVal + 1;
		endcase
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected effect of one instruction on the model.
	task automatic applyModel(input logic [6:0] instr, input logic [`DATA_WIDTH-1:0] din);
		logic [2:0] opx;
		logic [2:0] arg;
		logic       inc;
		opx = instr[3:1];
		arg = instr[6:4];
		inc = instr[0];
		case (opx)
			OP_RD_REG: begin
				expDout = regModel[expAddr[REG_BITS-1:0]];
				if (inc) expAddr = expAddr + 1;
			end
			OP_RD_CC: begin
				expDout = (ccState >> {arg[1:0], 2'b00}) & 16'h000F;
			end
			OP_RD_PC: begin
				expDout = pcRule(arg, pc, din);
			end
			OP_RD_MEM: begin
				expDout = memModel[expAddr[`MEM_ADDR_BITS-1:0]];
				if (inc) expAddr = expAddr + 1;
			end
			OP_WR_MEM: begin
				memModel[expAddr[`MEM_ADDR_BITS-1:0]] = din;
				if (inc) expAddr = expAddr + 1;
			end
			// none and the undefined codes leave the model alone.
		endcase
	endtask

	// ***********************************************************
	// bus tasks entered and left 1 ns after a rising edge.
	// ***********************************************************
	task automatic loadAddr(input logic [`ADDR_WIDTH-1:0] a);
		debugAddrLd = 1'b1;
		debugAddrIn = a;
		@(posedge clk);
		#1;
		debugAddrLd = 1'b0;
		expAddr = a;
		checkEq(32'(debugAddr), 32'(expAddr), "debug address after load");
	endtask

	task automatic writeReg(input logic [REG_BITS-1:0] idx, input logic [`DATA_WIDTH-1:0] d);
		regWe    = 1'b1;
		regWaddr = idx;
		regWdata = d;
		@(posedge clk);
		#1;
		regWe = 1'b0;
		regModel[idx] = d;
	endtask

	// hammer keeps the strobe high with junk instructions while busy.
	task automatic runOp(input logic [6:0] instr, input logic [`DATA_WIDTH-1:0] din,
		input logic hammer);
		int          cycles;
		logic [31:0] r;
		applyModel(instr, din);
		debugStrobe      = 1'b1;
		debugInstruction = instr;
		debugDin         = din;
		@(posedge clk);
		#1;
		checkEq(32'(debugBusy), 32'd1, "busy after accepted strobe");
		r = nextRand();
		debugStrobe      = hammer;
		debugInstruction = r[6:0];
		cycles = 0;
		while (!debugDone) begin
			if (cycles >= MAX_WAIT) begin
				$display("Timeout: no done pulse for instruction %0h", instr);
				$display("Test FAILED");
				$fatal(1, "done pulse missing");
			end
			@(posedge clk);
			#1;
			cycles++;
			debugStrobe = hammer && !debugDone;
			if (!debugDone) begin
				checkEq(32'(debugBusy), 32'd1, "busy while the op runs");
			end
		end
		checkEq(32'(cycles), 32'd2, "cycles from strobe to done");
		checkEq(32'(debugBusy), 32'd0, "busy with done");
		checkEq(32'(debugDout), 32'(expDout), "read-back data");
		checkEq(32'(debugAddr), 32'(expAddr), "debug address after op");
		@(posedge clk);
		#1;
		checkEq(32'(debugDone), 32'd0, "done pulse longer than one cycle");
		checkEq(32'(debugBusy), 32'd0, "busy after done");
		checkEq(32'(debugDout), 32'(expDout), "read-back data when idle");
		checkEq(32'(debugAddr), 32'(expAddr), "debug address when idle");
	endtask

	// ***********************************************************
	// test sequence.
	// ***********************************************************
	initial begin
		logic [31:0]            r;
		logic [`ADDR_WIDTH-1:0] base;
		logic [2:0]             opx;
		rngState         = 32'h49241831;
		rstN             = 1'b0;
		debugStrobe      = 1'b0;
		debugInstruction = '0;
		debugDin         = '0;
		debugAddrLd      = 1'b0;
		debugAddrIn      = '0;
		regWe            = 1'b0;
		regWaddr         = '0;
		regWdata         = '0;
		pc               = '0;
		ccState          = '0;
		expAddr          = '0;
		expDout          = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			regModel[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;

		checkEq(32'(debugBusy), 32'd0, "busy after reset");
		checkEq(32'(debugDone), 32'd0, "done after reset");
		checkEq(32'(debugDout), 32'd0, "read-back data after reset");
		checkEq(32'(debugAddr), 32'd0, "debug address after reset");

		// memory round trip.
		r = nextRand();
		base = r[15:0];
		loadAddr(base);
		for (int i = 0; i < NUM_WORDS; i++) begin
			r = nextRand();
			runOp(makeInstr(OP_WR_MEM, r[18:16], 1'b1), r[15:0], 1'b0);
		end
		loadAddr(base);
		for (int i = 0; i < NUM_WORDS; i++) begin
			r = nextRand();
			if (r[20]) begin
				runOp(makeInstr(OP_RD_MEM, r[18:16], 1'b0), r[15:0], 1'b0);
			end
			r = nextRand();
			runOp(makeInstr(OP_RD_MEM, r[18:16], 1'b1), r[15:0], 1'b0);
		end

		// register reads.
		for (int i = 0; i < `REG_COUNT; i++) begin
			r = nextRand();
			writeReg(REG_BITS'(i), r[15:0]);
		end
		for (int i = 0; i < NUM_REG_READS; i++) begin
			r = nextRand();
			if (r[24] || i == 0) begin
				loadAddr(r[15:0]);
			end
			r = nextRand();
			runOp(makeInstr(OP_RD_REG, r[18:16], r[19]), r[15:0], 1'b0);
		end

		// condition codes and next pc.
		for (int i = 0; i < NUM_CCPC; i++) begin
			r = nextRand();
			pc      = r[15:0];
			ccState = r[31:16];
			r = nextRand();
			opx = r[20] ? OP_RD_PC : OP_RD_CC;
			runOp(makeInstr(opx, r[18:16], r[19]), r[15:0], 1'b0);
		end

		// no-effect codes and strobes while busy.
		for (int i = 0; i < NUM_QUIET; i++) begin
			r = nextRand();
			if (i % 2 == 0) begin
				opx = QUIET_OPS[r[1:0]];
			end else begin
				opx = BUSY_OPS[r[1:0]];
			end
			runOp(makeInstr(opx, r[6:4], r[2]), r[31:16], (i % 2 == 1) || r[3]);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/debugPkg.sv
design/debugDecoder.sv
design/debugSequencer.sv
design/debugAddrReg.sv
design/debugDataPath.sv
design/debugMemory.sv
design/debugRegFile.sv
design/debugTop.sv
verif/debugTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps
TOP       = debugTb
LINT_TOP  = debugTop
FILELIST  = files.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
